/* rtl/sram_pkg.sv */
package sram_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths of the external 256K x 16 part

	typedef logic [17:0] sram_addr_t;      // word address, 2^18 words
	typedef logic [15:0] sram_data_t;      // one data word
	typedef logic [1:0]  sram_be_t;        // [1] upper byte, [0] lower byte
	typedef logic [2:0]  wait_cnt_t;       // hold timer count

	//////////////////////////////////////////////////////////////////////
	// access timing, 80 ns at 100 MHz

	localparam int        WAIT_CYCLES = 8;                         // hold cycles per access
	localparam wait_cnt_t WAIT_LAST   = wait_cnt_t'(WAIT_CYCLES - 1); // count in last hold cycle

	//////////////////////////////////////////////////////////////////////
	// controller FSM

	typedef enum logic [2:0] {
		st_idle    = 3'd0,                 // waiting for a request
		st_wr_hold = 3'd1,                 // address, data and we_n held
		st_wr_end  = 3'd2,                 // we_n released, bus off
		st_rd_hold = 3'd3,                 // address and oe_n held
		st_rd_end  = 3'd4,                 // bus sampled at end of cycle
		st_rsp     = 3'd5                  // read word offered on rsp port
	} sram_state_t;

endpackage

/* rtl/sram_wait_timer.sv */
module sram_wait_timer
	import sram_pkg::*;
(
	input  logic CLOCK,
	input  logic RESET,
	input  logic run,                  // high in the hold states
	output logic hold_done             // last hold cycle
);

	wait_cnt_t count;                  // hold cycles elapsed

	//////////////////////////////////////////////////////////////////////
	// hold counter

	// first hold cycle sees zero, since run was low the cycle before
	always_ff @(posedge CLOCK or negedge RESET) begin
		if (!RESET) begin
			count <= '0;
		end else if (!run) begin
			count <= '0;               // clear between accesses
		end else begin
			count <= count + wait_cnt_t'(1); // wraps as the hold ends
		end
	end

	assign hold_done = (count == WAIT_LAST); // WAIT_CYCLES-th hold cycle

endmodule

/* rtl/sram_ctrl_fsm.sv */
module sram_ctrl_fsm
	import sram_pkg::*;
(
	input  logic CLOCK,
	input  logic RESET,
	input  logic req_valid,
	input  logic cur_write,            // write flag, bypassed from req_write on accept
	input  logic hold_done,
	input  logic rsp_ready,
	output logic req_ready,
	output logic accept,
	output logic run,
	output logic drive_en,
	output logic rd_capture,
	output logic busy,
	output logic rsp_valid
);

	sram_state_t state;                // current state
	sram_state_t state_nxt;            // next state

	//////////////////////////////////////////////////////////////////////
	// state register

	always_ff @(posedge CLOCK or negedge RESET) begin
		if (!RESET) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state

	always_comb begin
		state_nxt = state;             // hold by default
		case (state)
			st_idle: begin
				if (accept) begin
					state_nxt = cur_write ? st_wr_hold : st_rd_hold;
				end
			end
			st_wr_hold: begin
				if (hold_done) begin
					state_nxt = st_wr_end;
				end
			end
			st_wr_end: begin
				state_nxt = st_idle;   // one cycle only
			end
			st_rd_hold: begin
				if (hold_done) begin
					state_nxt = st_rd_end;
				end
			end
			st_rd_end: begin
				state_nxt = st_rsp;    // word captured on this edge
			end
			st_rsp: begin
				if (rsp_ready) begin
					state_nxt = st_idle; // response taken
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// output decode

	// the pin strobes are registered in the data path, so drive_en and
	// busy look at the next state and the pins line up with the state
	assign req_ready  = (state == st_idle);
	assign accept     = req_valid && req_ready;       // request handshake
	assign rsp_valid  = (state == st_rsp);
	assign run        = (state == st_wr_hold) || (state == st_rd_hold); // timer runs in holds
	assign rd_capture = (state == st_rd_end);         // sample bus at end of cycle
	assign drive_en   = (state_nxt == st_wr_hold);    // bus and we_n next cycle
	assign busy       = (state_nxt != st_idle) && (state_nxt != st_rsp); // ce_n next cycle

endmodule

/* rtl/sram_data_path.sv */
module sram_data_path
	import sram_pkg::*;
(
	input  logic       CLOCK,
	input  logic       RESET,
	input  logic       accept,         // request taken this edge
	input  logic       drive_en,       // write hold next cycle
	input  logic       rd_capture,     // last read cycle
	input  logic       busy,           // access in progress next cycle
	input  logic       req_write,
	input  sram_addr_t req_addr,
	input  sram_data_t req_wdata,
	input  sram_be_t   req_be,
	output logic       cur_write,
	output sram_data_t rsp_rdata,
	output sram_addr_t sram_addr,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	output logic       sram_ub_n,
	output logic       sram_lb_n,
	output logic       sram_ce_n,
	inout  sram_data_t sram_db
);

	sram_addr_t addr_q;                // latched address
	sram_data_t wdata_q;               // latched write word
	sram_be_t   be_q;                  // latched byte mask
	logic       write_q;               // latched direction of request
	sram_be_t   be_cur;                // mask of the access in hand
	logic       dir_q;                 // 1 drives the bus

	//////////////////////////////////////////////////////////////////////
	// request latches

	always_ff @(posedge CLOCK) begin
		if (accept) begin
			addr_q  <= req_addr;
			wdata_q <= req_wdata;
			be_q    <= req_be;
		end
	end

	always_ff @(posedge CLOCK or negedge RESET) begin
		if (!RESET) begin
			write_q <= 1'b0;
		end else if (accept) begin
			write_q <= req_write;
		end
	end

	// bypass on the accept cycle so the FSM picks the right hold state
	assign cur_write = accept ? req_write : write_q;
	assign be_cur    = accept ? req_be : be_q;
	assign sram_addr = addr_q;         // address straight from the latch

	//////////////////////////////////////////////////////////////////////
	// registered strobes and bus direction

	always_ff @(posedge CLOCK or negedge RESET) begin
		if (!RESET) begin
			dir_q     <= 1'b0;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b1;
			sram_ce_n <= 1'b1;
			sram_ub_n <= 1'b1;
			sram_lb_n <= 1'b1;
		end else begin
			dir_q     <= drive_en;
			sram_we_n <= !drive_en;              // low only while driving
			sram_oe_n <= !(busy && !cur_write);  // read hold and read end
			sram_ce_n <= !busy;                  // chip on during access only
			if (busy && cur_write) begin
				sram_ub_n <= !be_cur[1];         // lanes from the mask
				sram_lb_n <= !be_cur[0];
			end else if (busy) begin
				sram_ub_n <= 1'b0;               // reads take both bytes
				sram_lb_n <= 1'b0;
			end else begin
				sram_ub_n <= 1'b1;
				sram_lb_n <= 1'b1;
			end
		end
	end

	assign sram_db = dir_q ? wdata_q : 'z; // tristate driver

	//////////////////////////////////////////////////////////////////////
	// read capture, held until the next read

	always_ff @(posedge CLOCK) begin
		if (rd_capture) begin
			rsp_rdata <= sram_db;
		end
	end

endmodule

/* rtl/sram_ctrl_top.sv */
module sram_ctrl_top
	import sram_pkg::*;
(
	input  logic       CLOCK,
	input  logic       RESET,

	// request port
	input  logic       req_valid,
	input  logic       req_write,
	input  sram_addr_t req_addr,
	input  sram_data_t req_wdata,
	input  sram_be_t   req_be,
	output logic       req_ready,

	// response port, reads only
	output logic       rsp_valid,
	output sram_data_t rsp_rdata,
	input  logic       rsp_ready,

	// external SRAM pins
	output sram_addr_t sram_addr,
	inout  sram_data_t sram_db,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	output logic       sram_ub_n,
	output logic       sram_lb_n,
	output logic       sram_ce_n
);

	logic accept;                      // request handshake
	logic run;                         // timer enable
	logic hold_done;                   // timer expiry
	logic drive_en;                    // write drive, next cycle
	logic rd_capture;                  // read sample strobe
	logic busy;                        // chip enable, next cycle
	logic cur_write;                   // direction of the access in hand

	//////////////////////////////////////////////////////////////////////
	// sequencing

	sram_ctrl_fsm u_fsm (
		.CLOCK      (CLOCK),
		.RESET      (RESET),
		.req_valid  (req_valid),
		.cur_write  (cur_write),
		.hold_done  (hold_done),
		.rsp_ready  (rsp_ready),
		.req_ready  (req_ready),
		.accept     (accept),
		.run        (run),
		.drive_en   (drive_en),
		.rd_capture (rd_capture),
		.busy       (busy),
		.rsp_valid  (rsp_valid)
	);

	sram_wait_timer u_timer (
		.CLOCK     (CLOCK),
		.RESET     (RESET),
		.run       (run),
		.hold_done (hold_done)
	);

	//////////////////////////////////////////////////////////////////////
	// pins and data

	sram_data_path u_data_path (
		.CLOCK      (CLOCK),
		.RESET      (RESET),
		.accept     (accept),
		.drive_en   (drive_en),
		.rd_capture (rd_capture),
		.busy       (busy),
		.req_write  (req_write),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.req_be     (req_be),
		.cur_write  (cur_write),
		.rsp_rdata  (rsp_rdata),
		.sram_addr  (sram_addr),
		.sram_we_n  (sram_we_n),
		.sram_oe_n  (sram_oe_n),
		.sram_ub_n  (sram_ub_n),
		.sram_lb_n  (sram_lb_n),
		.sram_ce_n  (sram_ce_n),
		.sram_db    (sram_db)
	);

endmodule

/* sim/sram_model.sv */
module sram_model
	import sram_pkg::*;
(
	input  sram_addr_t addr,
	inout  sram_data_t db,
	input  logic       we_n,
	input  logic       oe_n,
	input  logic       ub_n,
	input  logic       lb_n,
	input  logic       ce_n
);

	localparam int DEPTH = 1 << $bits(sram_addr_t);   // 256K words

	sram_data_t mem [DEPTH];           // storage array
	sram_addr_t wr_addr;               // address seen while we_n low
	sram_data_t wr_data;               // bus word seen while we_n low
	logic       wr_ub_n;               // upper strobe seen while we_n low
	logic       wr_lb_n;               // lower strobe seen while we_n low

	initial begin
		mem = '{default: '0};          // unwritten words read as zero
	end

	// output enable path, reads both lanes
	assign db = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

	//////////////////////////////////////////////////////////////////////
	// write cycle, committed on the rising edge of we_n

	// the controller releases the bus on the same edge that raises we_n,
	// so the write word is held from the low phase of we_n
	always_latch begin
		if (!ce_n && !we_n) begin
			wr_addr <= addr;
			wr_data <= db;
			wr_ub_n <= ub_n;
			wr_lb_n <= lb_n;
		end
	end

	always @(posedge we_n) begin
		if (!ce_n) begin
			if (!wr_ub_n) begin
				mem[wr_addr][15:8] <= wr_data[15:8];   // upper lane
			end
			if (!wr_lb_n) begin
				mem[wr_addr][7:0] <= wr_data[7:0];     // lower lane
			end
		end
	end

endmodule

/* sim/tb_sram_ctrl.sv */
module tb_sram_ctrl
	import sram_pkg::*;
();

	localparam int POOL_SIZE  = 16;    // addresses shared by all tests
	localparam int MIX_OPS    = 100;   // requests in the back-pressure test
	localparam int WAIT_LIMIT = 40;    // cycles for one handshake
	localparam int MIX_LIMIT  = 20000; // cycles for the whole mixed run

	logic       CLOCK;
	logic       RESET;
	logic       req_valid;
	logic       req_write;
	sram_addr_t req_addr;
	sram_data_t req_wdata;
	sram_be_t   req_be;
	logic       req_ready;
	logic       rsp_valid;
	sram_data_t rsp_rdata;
	logic       rsp_ready;
	sram_addr_t sram_addr;
	wire sram_data_t sram_db;
	logic       sram_we_n;
	logic       sram_oe_n;
	logic       sram_ub_n;
	logic       sram_lb_n;
	logic       sram_ce_n;

	logic       probe_en;              // testbench drive on the bus
	sram_data_t probe_val;

	sram_data_t ref_mem [sram_addr_t]; // sparse reference memory
	sram_addr_t pool [POOL_SIZE];
	int         errors;
	int         checks;
	int         tests;
	int         test_start;            // error count when the test began
	event       run_done;

	initial CLOCK = 1'b0;
	always #4 CLOCK = ~CLOCK;          // period 8

	assign sram_db = probe_en ? probe_val : 'z;

	sram_ctrl_top DUT (
		.CLOCK     (CLOCK),
		.RESET     (RESET),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_be    (req_be),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.rsp_ready (rsp_ready),
		.sram_addr (sram_addr),
		.sram_db   (sram_db),
		.sram_we_n (sram_we_n),
		.sram_oe_n (sram_oe_n),
		.sram_ub_n (sram_ub_n),
		.sram_lb_n (sram_lb_n),
		.sram_ce_n (sram_ce_n)
	);

	sram_model u_sram (
		.addr (sram_addr),
		.db   (sram_db),
		.we_n (sram_we_n),
		.oe_n (sram_oe_n),
		.ub_n (sram_ub_n),
		.lb_n (sram_lb_n),
		.ce_n (sram_ce_n)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model and reporting

	function automatic sram_data_t ref_read(sram_addr_t addr);
		if (ref_mem.exists(addr)) begin
			return ref_mem[addr];
		end
		return '0;                     // never written
	endfunction

	function automatic void ref_write(sram_addr_t addr, sram_data_t data, sram_be_t be);
		sram_data_t old;
		old = ref_read(addr);
		ref_mem[addr] = {be[1] ? data[15:8] : old[15:8], be[0] ? data[7:0] : old[7:0]};
	endfunction

	function automatic sram_addr_t pick_addr();
		return pool[4'($urandom)];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic timeout_stop(input string what);
		report_problem({"timed out waiting for ", what});
		-> run_done;
		forever @(posedge CLOCK);      // parked until the reporter ends the run
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s, %0d errors", tests, name,
			(errors == test_start) ? "ok" : "failed", errors - test_start);
		test_start = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// request and response handshakes

	task automatic send_request(input logic write, input sram_addr_t addr,
			input sram_data_t wdata, input sram_be_t be);
		logic taken;
		int   n;
		req_write = write;
		req_addr  = addr;
		req_wdata = wdata;
		req_be    = be;
		req_valid = 1'b1;
		taken = 1'b0;
		n = 0;
		while (!taken) begin
			taken = req_ready;         // ready as seen by the next edge
			@(posedge CLOCK);
			#1;
			n++;
			if (!taken && n > WAIT_LIMIT) begin
				timeout_stop("req_ready");
			end
		end
		req_valid = 1'b0;
	endtask

	// edge counts include the accepting edge
	task automatic write_word(input sram_addr_t addr, input sram_data_t data,
			input sram_be_t be, output int edges);
		send_request(1'b1, addr, data, be);
		ref_write(addr, data, be);
		edges = 1;
		while (!req_ready) begin
			check_value("sram_addr", 32'(sram_addr), 32'(addr)); // held through the access
			@(posedge CLOCK);
			#1;
			edges++;
			if (edges > WAIT_LIMIT) begin
				timeout_stop("end of write");
			end
		end
	endtask

	task automatic read_check(input sram_addr_t addr, output int edges);
		sram_data_t data;
		send_request(1'b0, addr, '0, sram_be_t'($urandom));
		edges = 1;
		while (!rsp_valid) begin
			check_value("req_ready", 32'(req_ready), 32'd0);  // busy
			check_value("sram_addr", 32'(sram_addr), 32'(addr));
			@(posedge CLOCK);
			#1;
			edges++;
			if (edges > WAIT_LIMIT) begin
				timeout_stop("rsp_valid");
			end
		end
		check_value("req_ready", 32'(req_ready), 32'd0);      // response pending
		data = rsp_rdata;
		rsp_ready = 1'b1;
		@(posedge CLOCK);
		#1;
		rsp_ready = 1'b0;
		check_value("rsp_valid", 32'(rsp_valid), 32'd0);      // taken once
		check_value("rsp_rdata", 32'(data), 32'(ref_read(addr)));
	endtask

	// a probe word reads back unchanged on a released bus
	task automatic probe_bus();
		probe_en  = 1'b1;
		probe_val = 16'ha5c3;
		#1;
		check_value("sram_db", 32'(sram_db), 32'h0000a5c3);
		probe_val = 16'h5a3c;
		#1;
		check_value("sram_db", 32'(sram_db), 32'h00005a3c);
		probe_en = 1'b0;
		@(posedge CLOCK);
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// mixed traffic with response stalls

	task automatic run_mixed_traffic();
		sram_data_t exp_q[$];          // words owed by pending reads
		sram_data_t rdata_q;
		logic       ready_q;
		logic       valid_q;
		logic       acc;
		logic       took;
		int         issued;
		int         cycles;
		int         stretch;
		issued = 0;
		cycles = 0;
		stretch = 0;
		while (issued < MIX_OPS || exp_q.size() > 0) begin
			ready_q = req_ready;       // values before the coming edge
			valid_q = rsp_valid;
			rdata_q = rsp_rdata;
			if (!req_valid && issued < MIX_OPS && ($urandom % 4) != 0) begin
				req_write = 1'($urandom);
				req_addr  = pick_addr();
				req_wdata = sram_data_t'($urandom);
				req_be    = sram_be_t'($urandom);
				req_valid = 1'b1;
			end
			if (stretch == 0) begin
				rsp_ready = 1'($urandom);
				stretch = 1 + int'($urandom % 6);   // random stall length
			end
			stretch--;
			@(posedge CLOCK);
			#1;
			acc  = req_valid && ready_q;
			took = valid_q && rsp_ready;
			if (valid_q) begin
				check_value("req_ready", 32'(ready_q), 32'd0);
			end
			if (acc) begin
				issued++;
				req_valid = 1'b0;
				if (req_write) begin
					ref_write(req_addr, req_wdata, req_be);
				end else begin
					exp_q.push_back(ref_read(req_addr));
				end
			end
			if (took) begin
				if (exp_q.size() == 0) begin
					report_problem("read response taken with no read outstanding");
				end else begin
					check_value("rsp_rdata", 32'(rdata_q), 32'(exp_q.pop_front()));
				end
				check_value("rsp_valid", 32'(rsp_valid), 32'd0);  // no duplicate
			end else if (valid_q) begin
				check_value("rsp_valid", 32'(rsp_valid), 32'd1);  // held
				check_value("rsp_rdata", 32'(rsp_rdata), 32'(rdata_q));
			end else if (rsp_valid && exp_q.size() == 0) begin
				report_problem("rsp_valid rose with no read outstanding");
			end
			cycles++;
			if (cycles > MIX_LIMIT) begin
				timeout_stop("mixed traffic to drain");
			end
		end
		rsp_ready = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		sram_addr_t addr_q[$];
		sram_addr_t a;
		int         edges;
		void'($urandom(48));
		RESET     = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		req_be    = '0;
		rsp_ready = 1'b0;
		probe_en  = 1'b0;
		probe_val = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		test_start = 0;
		for (int i = 0; i < POOL_SIZE; i++) begin
			pool[4'(i)] = sram_addr_t'($urandom);
		end
		repeat (4) @(posedge CLOCK);
		#1;
		RESET = 1'b1;

		check_value("req_ready", 32'(req_ready), 32'd1);
		check_value("rsp_valid", 32'(rsp_valid), 32'd0);
		check_value("sram_we_n", 32'(sram_we_n), 32'd1);
		check_value("sram_oe_n", 32'(sram_oe_n), 32'd1);
		check_value("sram_ce_n", 32'(sram_ce_n), 32'd1);
		check_value("sram_ub_n", 32'(sram_ub_n), 32'd1);
		check_value("sram_lb_n", 32'(sram_lb_n), 32'd1);
		probe_bus();
		end_test("reset state");

		for (int i = 0; i < 20; i++) begin
			a = pick_addr();
			write_word(a, sram_data_t'($urandom), 2'b11, edges);
			addr_q.push_back(a);
		end
		while (addr_q.size() > 0) begin
			read_check(addr_q.pop_front(), edges);
		end
		end_test("full word write and read");

		for (int i = 0; i < 4; i++) begin
			a = pick_addr();
			write_word(a, 16'hc3a5, 2'b11, edges);   // known base word
			write_word(a, sram_data_t'($urandom), 2'b01, edges);
			read_check(a, edges);
			write_word(a, sram_data_t'($urandom), 2'b10, edges);
			read_check(a, edges);
		end
		end_test("byte lanes");

		a = pick_addr();
		write_word(a, sram_data_t'($urandom), 2'b11, edges);
		check_value("req_ready edges", 32'(edges), 32'(WAIT_CYCLES + 2));
		probe_bus();
		read_check(a, edges);
		check_value("rsp_valid edges", 32'(edges), 32'(WAIT_CYCLES + 2));
		end_test("busy and latency");

		run_mixed_traffic();
		end_test("response back-pressure");
		-> run_done;
	end

	initial begin
		@(run_done);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* files.f */
rtl/sram_pkg.sv
rtl/sram_wait_timer.sv
rtl/sram_ctrl_fsm.sv
rtl/sram_data_path.sv
rtl/sram_ctrl_top.sv
sim/sram_model.sv
sim/tb_sram_ctrl.sv

/* Makefile */
# Verilator build and run of the SRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_ctrl
LOG       ?= sim.log
BUILD     ?= build
VFLAGS    ?= --binary --timing -j 0

SRCS := $(filter-out +%,$(shell cat files.f))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when the list or a source changes
$(BIN): files.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f files.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^Finished with no errors$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
